// ==== design/raygen_pkg.sv ====
`default_nettype none

package raygen_pkg;

    // signed Q8.24 fixed point
    localparam int FP_FRAC_BITS = 24;

    typedef logic signed [31:0] fp;

    localparam fp FP_ONE        = 32'h0100_0000;
    localparam fp FP_HALF       = 32'h0080_0000;
    // newton step constant
    localparam fp FP_THREE_HALF = 32'h0180_0000;
    // saturation value, also the answer for a zero input
    localparam fp FP_MAX        = 32'h7FFF_FFFF;

    // screen coordinate, unsigned
    typedef logic [11:0] coord_t;

    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    // pixel tag that rides along with each ray
    typedef struct packed {
        coord_t px;
        coord_t py;
    } pixel_t;

    // pipeline depths
    localparam int INV_SQRT_LATENCY = 7;
    // ndc + view ray + length + inv_sqrt + normalize
    localparam int RAY_LATENCY      = INV_SQRT_LATENCY + 4;

    // fixed camera basis, looking down z
    localparam vec3 CAMERA_RIGHT = '{x: FP_ONE, y: '0, z: '0};
    localparam vec3 CAMERA_UP    = '{x: '0, y: FP_ONE, z: '0};

    // full product, drop the low fraction bits
    function automatic fp fp_mul(input fp a, input fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return prod[FP_FRAC_BITS +: 32];
    endfunction

    function automatic fp vec3_dot(input vec3 a, input vec3 b);
        return fp_mul(a.x, b.x) + fp_mul(a.y, b.y) + fp_mul(a.z, b.z);
    endfunction

    function automatic vec3 make_vec3(input fp vx, input fp vy, input fp vz);
        vec3 v;
        v.x = vx;
        v.y = vy;
        v.z = vz;
        return v;
    endfunction

    // integer coordinate into the Q8.24 integer part
    // only values below 128 survive
    function automatic fp int_to_fp(input coord_t c);
        return fp'(32'(c) << FP_FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

// ==== design/inv_sqrt.sv ====
`default_nettype none
`timescale 1ns/1ps

module inv_sqrt (
    input  logic          clk,
    input  logic          rst,
    input  logic          valid_in,
    input  raygen_pkg::fp x,
    output logic          valid_out,
    output raygen_pkg::fp inv_sqrt
);

    import raygen_pkg::*;

    // signed half of the normalization shift
    typedef logic signed [5:0] exp_t;

    // per-stage payload
    typedef struct packed {
        fp    m;
        fp    y;
        fp    t;
        exp_t k;
        logic zero;
    } stage_t;

    stage_t      st [1:6];
    logic        vld [1:6];
    logic [4:0]  msb_pos;
    exp_t        even_shift;
    fp           norm_m;
    logic [3:0]  seed_idx;
    logic [63:0] wide_y;

    // 1/sqrt at the midpoint of each mantissa segment
    // low half covers [0.25,0.5) in steps of 1/32, high half [0.5,1) in steps of 1/16
    function automatic fp seed_lookup(input logic [3:0] idx);
        case (idx)
            4'd0:    return 32'h01F0_B600;
            4'd1:    return 32'h01D5_D800;
            4'd2:    return 32'h01BE_E900;
            4'd3:    return 32'h01AB_0A00;
            4'd4:    return 32'h0199_9A00;
            4'd5:    return 32'h018A_2300;
            4'd6:    return 32'h017C_4E00;
            4'd7:    return 32'h016F_D500;
            4'd8:    return 32'h015F_3B00;
            4'd9:    return 32'h014C_3B00;
            4'd10:   return 32'h013C_0300;
            4'd11:   return 32'h012D_F600;
            4'd12:   return 32'h0121_A200;
            4'd13:   return 32'h0116_B300;
            4'd14:   return 32'h010C_EA00;
            default: return 32'h0104_1900;
        endcase
    endfunction

    // leading one and an even shift that puts it at bit 22 or 23
    always_comb begin
        msb_pos = '0;
        for (int i = 0; i < 31; i++) begin
            if (x[i]) begin
                msb_pos = 5'(i);
            end
        end
        even_shift = 6'(signed'({1'b0, msb_pos}) - 6'sd22);
        // round down to even so sqrt splits cleanly
        even_shift[0] = 1'b0;
        if (even_shift[5]) begin
            norm_m = x << (-even_shift);
        end else begin
            norm_m = x >> even_shift;
        end
    end

    // stage 1: normalize into [0.25,1)
    always_ff @(posedge clk) begin
        if (!rst) begin
            st[1]  <= '0;
            vld[1] <= 1'b0;
        end else begin
            vld[1] <= valid_in;
            if (valid_in) begin
                st[1].m    <= norm_m;
                st[1].y    <= '0;
                st[1].t    <= '0;
                st[1].k    <= even_shift >>> 1;
                // negative treated like zero
                st[1].zero <= x[31] || (x == '0);
            end
        end
    end

    // table index, top mantissa bits below the leading one
    assign seed_idx = st[1].m[23] ? {1'b1, st[1].m[22:20]} : {1'b0, st[1].m[21:19]};

    // stage 2: seed
    always_ff @(posedge clk) begin
        if (!rst) begin
            st[2]  <= '0;
            vld[2] <= 1'b0;
        end else begin
            vld[2] <= vld[1];
            if (vld[1]) begin
                st[2]   <= st[1];
                st[2].y <= seed_lookup(seed_idx);
            end
        end
    end

    // stages 3 to 6: two newton steps, y = y * (1.5 - x*y*y/2)
    for (genvar i = 0; i < 2; i++) begin : g_newton
        // first half, x times y squared
        always_ff @(posedge clk) begin
            if (!rst) begin
                st[3+2*i]  <= '0;
                vld[3+2*i] <= 1'b0;
            end else begin
                vld[3+2*i] <= vld[2+2*i];
                if (vld[2+2*i]) begin
                    st[3+2*i]   <= st[2+2*i];
                    st[3+2*i].t <= fp_mul(st[2+2*i].m, fp_mul(st[2+2*i].y, st[2+2*i].y));
                end
            end
        end

        // second half, refined estimate
        always_ff @(posedge clk) begin
            if (!rst) begin
                st[4+2*i]  <= '0;
                vld[4+2*i] <= 1'b0;
            end else begin
                vld[4+2*i] <= vld[3+2*i];
                if (vld[3+2*i]) begin
                    st[4+2*i]   <= st[3+2*i];
                    st[4+2*i].y <= fp_mul(st[3+2*i].y, FP_THREE_HALF - (st[3+2*i].t >>> 1));
                end
            end
        end
    end

    // undo normalization, 1/sqrt(m * 4^k) = y * 2^-k
    always_comb begin
        if (st[6].k[5]) begin
            wide_y = {32'd0, st[6].y} << (-st[6].k);
        end else begin
            wide_y = {32'd0, st[6].y} >> st[6].k;
        end
    end

    // stage 7: denormalize and saturate tiny inputs
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_out <= 1'b0;
            inv_sqrt  <= '0;
        end else begin
            valid_out <= vld[6];
            if (vld[6]) begin
                if (st[6].zero || (wide_y > 64'h0000_0000_7FFF_FFFF)) begin
                    inv_sqrt <= FP_MAX;
                end else begin
                    inv_sqrt <= wide_y[31:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ray_generator.sv ====
`default_nettype none
`timescale 1ns/1ps

module ray_generator #(
    // coordinates must stay below 128 to fit Q8.24
    parameter int SCREEN_WIDTH  = 64,
    parameter int SCREEN_HEIGHT = 48
) (
    input  logic               clk,
    input  logic               rst,
    input  raygen_pkg::pixel_t pixel,
    input  logic               valid_in,
    input  logic               last_in,
    input  raygen_pkg::vec3    camera_forward,
    output raygen_pkg::vec3    ray_direction,
    output raygen_pkg::pixel_t ray_pixel,
    output logic               valid_out,
    output logic               last_out
);

    import raygen_pkg::*;

    // 2/width and 2/height, fixed at elaboration
    localparam fp SCALE_X = fp'((64'sd2 <<< FP_FRAC_BITS) / SCREEN_WIDTH);
    localparam fp SCALE_Y = fp'((64'sd2 <<< FP_FRAC_BITS) / SCREEN_HEIGHT);

    // pixel tag plus frame end marker
    typedef struct packed {
        pixel_t pix;
        logic   last;
    } tag_t;

    fp    ndc_x;
    fp    ndc_y;
    logic valid_r1;
    vec3  ray;
    logic valid_r2;
    fp    ray_mag_sq;
    logic sq_valid;
    fp    inv_mag;
    logic inv_valid;
    // ray waits here while inv_sqrt runs
    vec3  ray_dly [0:INV_SQRT_LATENCY];
    // tag lines up with the normalize stage input
    tag_t tag_dly [0:RAY_LATENCY-2];

    // stage 1: pixel centre to [-1,1], y flipped so up is positive
    always_ff @(posedge clk) begin
        if (!rst) begin
            ndc_x    <= '0;
            ndc_y    <= '0;
            valid_r1 <= 1'b0;
        end else begin
            valid_r1 <= valid_in;
            if (valid_in) begin
                ndc_x <= fp_mul(int_to_fp(pixel.px) + FP_HALF, SCALE_X) - FP_ONE;
                ndc_y <= FP_ONE - fp_mul(int_to_fp(pixel.py) + FP_HALF, SCALE_Y);
            end
        end
    end

    // stage 2: view ray from the fixed basis and the forward vector
    always_ff @(posedge clk) begin
        if (!rst) begin
            ray      <= '0;
            valid_r2 <= 1'b0;
        end else begin
            valid_r2 <= valid_r1;
            if (valid_r1) begin
                ray.x <= fp_mul(ndc_x, CAMERA_RIGHT.x) + fp_mul(ndc_y, CAMERA_UP.x)
                         - camera_forward.x;
                ray.y <= fp_mul(ndc_x, CAMERA_RIGHT.y) + fp_mul(ndc_y, CAMERA_UP.y)
                         - camera_forward.y;
                ray.z <= fp_mul(ndc_x, CAMERA_RIGHT.z) + fp_mul(ndc_y, CAMERA_UP.z)
                         - camera_forward.z;
            end
        end
    end

    // stage 3: squared length
    always_ff @(posedge clk) begin
        if (!rst) begin
            ray_mag_sq <= '0;
            sq_valid   <= 1'b0;
        end else begin
            sq_valid <= valid_r2;
            if (valid_r2) begin
                ray_mag_sq <= vec3_dot(ray, ray);
            end
        end
    end

    inv_sqrt inv_sqrt_inst (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (sq_valid),
        .x         (ray_mag_sq),
        .valid_out (inv_valid),
        .inv_sqrt  (inv_mag)
    );

    // shift lines run every cycle, one slot per pixel in flight
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i <= INV_SQRT_LATENCY; i++) begin
                ray_dly[i] <= '0;
            end
            for (int i = 0; i <= RAY_LATENCY - 2; i++) begin
                tag_dly[i] <= '0;
            end
        end else begin
            ray_dly[0] <= ray;
            for (int i = 1; i <= INV_SQRT_LATENCY; i++) begin
                ray_dly[i] <= ray_dly[i-1];
            end
            // last only counts on a valid pixel
            tag_dly[0] <= '{pix: pixel, last: valid_in & last_in};
            for (int i = 1; i <= RAY_LATENCY - 2; i++) begin
                tag_dly[i] <= tag_dly[i-1];
            end
        end
    end

    // stage 11: scale to unit length, attach the tag
    always_ff @(posedge clk) begin
        if (!rst) begin
            ray_direction <= '0;
            ray_pixel     <= '0;
            valid_out     <= 1'b0;
            last_out      <= 1'b0;
        end else begin
            valid_out <= inv_valid;
            last_out  <= inv_valid & tag_dly[RAY_LATENCY-2].last;
            if (inv_valid) begin
                ray_direction.x <= fp_mul(ray_dly[INV_SQRT_LATENCY].x, inv_mag);
                ray_direction.y <= fp_mul(ray_dly[INV_SQRT_LATENCY].y, inv_mag);
                ray_direction.z <= fp_mul(ray_dly[INV_SQRT_LATENCY].z, inv_mag);
                ray_pixel       <= tag_dly[RAY_LATENCY-2].pix;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/pixel_scanner.sv ====
`default_nettype none
`timescale 1ns/1ps

module pixel_scanner #(
    parameter int SCREEN_WIDTH  = 64,
    parameter int SCREEN_HEIGHT = 48
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    output raygen_pkg::pixel_t pixel,
    output logic               pixel_valid,
    output logic               scan_done,
    output logic               busy
);

    import raygen_pkg::*;

    typedef enum logic {
        IDLE,
        SCAN
    } state_t;

    state_t state;
    coord_t x_cnt;
    coord_t y_cnt;
    coord_t x_next;
    coord_t y_next;
    logic   next_is_last;

    // next raster position, x fastest
    always_comb begin
        if (state == IDLE) begin
            x_next = '0;
            y_next = '0;
        end else if (x_cnt == coord_t'(SCREEN_WIDTH - 1)) begin
            x_next = '0;
            y_next = y_cnt + coord_t'(1);
        end else begin
            x_next = x_cnt + coord_t'(1);
            y_next = y_cnt;
        end
        next_is_last = (x_next == coord_t'(SCREEN_WIDTH - 1)) &&
                       (y_next == coord_t'(SCREEN_HEIGHT - 1));
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= IDLE;
            x_cnt       <= '0;
            y_cnt       <= '0;
            pixel_valid <= 1'b0;
            scan_done   <= 1'b0;
            busy        <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // first pixel goes out on the same edge
                    if (start) begin
                        state       <= SCAN;
                        busy        <= 1'b1;
                        pixel_valid <= 1'b1;
                        x_cnt       <= x_next;
                        y_cnt       <= y_next;
                        scan_done   <= next_is_last;
                    end
                end
                SCAN: begin
                    // start ignored here
                    if (scan_done) begin
                        state       <= IDLE;
                        busy        <= 1'b0;
                        pixel_valid <= 1'b0;
                        scan_done   <= 1'b0;
                    end else begin
                        x_cnt     <= x_next;
                        y_cnt     <= y_next;
                        scan_done <= next_is_last;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign pixel = '{px: x_cnt, py: y_cnt};

endmodule

`default_nettype wire

// ==== design/ray_frame_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module ray_frame_top #(
    parameter int SCREEN_WIDTH  = 64,
    parameter int SCREEN_HEIGHT = 48
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  raygen_pkg::vec3    camera_forward,
    output raygen_pkg::vec3    ray_direction,
    output raygen_pkg::pixel_t ray_pixel,
    output logic               ray_valid,
    output logic               frame_done,
    output logic               busy
);

    import raygen_pkg::*;

    // scanner to generator
    pixel_t pixel;
    logic   pixel_valid;
    logic   scan_done;

    pixel_scanner #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) pixel_scanner_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .scan_done   (scan_done),
        .busy        (busy)
    );

    // scan_done rides the tag line and comes back as frame_done
    ray_generator #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) ray_generator_inst (
        .clk            (clk),
        .rst            (rst),
        .pixel          (pixel),
        .valid_in       (pixel_valid),
        .last_in        (scan_done),
        .camera_forward (camera_forward),
        .ray_direction  (ray_direction),
        .ray_pixel      (ray_pixel),
        .valid_out      (ray_valid),
        .last_out       (frame_done)
    );

endmodule

`default_nettype wire

// ==== verification/ray_frame_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

module ray_frame_properties (
    input logic clk,
    input logic rst,
    input logic valid_in,
    input logic last_in,
    input logic valid_out,
    input logic last_out,
    input logic sq_valid,
    input logic inv_valid
);

    import raygen_pkg::*;

    // every ray traces back to a pixel a full pipeline earlier
    ray_has_source: assert property (@(posedge clk) disable iff (!rst)
        valid_out |-> $past(valid_in, RAY_LATENCY))
        else $error("valid_out without valid_in %0d cycles before", RAY_LATENCY);

    // frame end marker only on a real ray, and only for the last pixel
    last_needs_valid: assert property (@(posedge clk) disable iff (!rst)
        last_out |-> valid_out && $past(valid_in && last_in, RAY_LATENCY))
        else $error("last_out without a last pixel %0d cycles before", RAY_LATENCY);

    // inv_sqrt has a fixed depth, both directions
    inv_out_has_source: assert property (@(posedge clk) disable iff (!rst)
        inv_valid |-> $past(sq_valid, INV_SQRT_LATENCY))
        else $error("inv_sqrt valid_out without a matching valid_in");

    inv_out_not_lost: assert property (@(posedge clk) disable iff (!rst)
        $past(sq_valid, INV_SQRT_LATENCY) |-> inv_valid)
        else $error("inv_sqrt dropped or delayed a result");

endmodule

bind ray_generator ray_frame_properties ray_frame_properties_inst (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (valid_in),
    .last_in   (last_in),
    .valid_out (valid_out),
    .last_out  (last_out),
    .sq_valid  (sq_valid),
    .inv_valid (inv_valid)
);

`default_nettype wire

// ==== verification/ray_frame_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module ray_frame_checker #(
    parameter int SCREEN_WIDTH  = 8,
    parameter int SCREEN_HEIGHT = 6
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               busy,
    input  raygen_pkg::vec3    camera_forward,
    input  raygen_pkg::vec3    ray_direction,
    input  raygen_pkg::pixel_t ray_pixel,
    input  logic               ray_valid,
    input  logic               frame_done,
    input  int                 expected_rays,
    input  logic               expect_z_neg,
    output int                 error_count,
    output int                 frames_passed,
    output int                 frames_failed
);

    import raygen_pkg::*;

    // start seen at one edge, first ray twelve edges later
    localparam int  FIRST_RAY_DELAY = 12;
    localparam real DIR_TOL         = 1.0 / 1024.0;
    localparam real LEN_TOL         = 1.0 / 256.0;

    logic in_frame;
    logic z_neg;
    vec3  fwd;
    int   cycle;
    int   start_cycle;
    int   ray_idx;
    int   frame_idx;
    int   frame_errors;
    int   rays_expected;
    // scan cycles still to come, busy expected while nonzero
    int   scan_left;

    function automatic real to_real(input fp v);
        return $itor(v) / 16777216.0;
    endfunction

    function automatic real abs_real(input real v);
        return (v < 0.0) ? -v : v;
    endfunction

    task automatic count_error();
        error_count  = error_count + 1;
        frame_errors = frame_errors + 1;
    endtask

    task automatic report_int(input string name, input int expected, input int actual);
        $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        count_error();
    endtask

    task automatic report_real(input string name, input real expected, input real actual);
        $display("[ERROR] %0t %s expected %f actual %f", $time, name, expected, actual);
        count_error();
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %0t %s", $time, what);
        count_error();
    endtask

    // raster position, ndc, view ray, then real-valued normalization
    task automatic check_ray();
        int  ex_px;
        int  ex_py;
        real ndc_x;
        real ndc_y;
        real rx;
        real ry;
        real rz;
        real len;
        real ax;
        real ay;
        real az;
        ex_px = ray_idx % SCREEN_WIDTH;
        ex_py = ray_idx / SCREEN_WIDTH;
        if (ray_pixel.px != coord_t'(ex_px)) begin
            report_int("ray_pixel.px", ex_px, int'(ray_pixel.px));
        end
        if (ray_pixel.py != coord_t'(ex_py)) begin
            report_int("ray_pixel.py", ex_py, int'(ray_pixel.py));
        end
        ndc_x = (real'(ex_px) + 0.5) * 2.0 / real'(SCREEN_WIDTH) - 1.0;
        ndc_y = 1.0 - (real'(ex_py) + 0.5) * 2.0 / real'(SCREEN_HEIGHT);
        rx  = ndc_x - to_real(fwd.x);
        ry  = ndc_y - to_real(fwd.y);
        rz  = -to_real(fwd.z);
        len = $sqrt(rx * rx + ry * ry + rz * rz);
        ax  = to_real(ray_direction.x);
        ay  = to_real(ray_direction.y);
        az  = to_real(ray_direction.z);
        if (abs_real(ax - rx / len) > DIR_TOL) begin
            report_real("ray_direction.x", rx / len, ax);
        end
        if (abs_real(ay - ry / len) > DIR_TOL) begin
            report_real("ray_direction.y", ry / len, ay);
        end
        if (abs_real(az - rz / len) > DIR_TOL) begin
            report_real("ray_direction.z", rz / len, az);
        end
        // unit length check on the DUT output itself
        if (abs_real(ax * ax + ay * ay + az * az - 1.0) > LEN_TOL) begin
            report_real("ray_direction length squared", 1.0, ax * ax + ay * ay + az * az);
        end
        if (z_neg != ray_direction.z[31]) begin
            report_failure($sformatf("ray z points the wrong way at pixel %0d", ray_idx));
        end
    endtask

    task automatic close_frame();
        if (frame_errors == 0) begin
            $display("frame %0d ok, %0d rays", frame_idx, ray_idx);
            frames_passed = frames_passed + 1;
        end else begin
            $display("frame %0d FAILED, %0d errors", frame_idx, frame_errors);
            frames_failed = frames_failed + 1;
        end
        frame_idx = frame_idx + 1;
        in_frame  = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            in_frame      = 1'b0;
            z_neg         = 1'b0;
            fwd           = '0;
            cycle         = 0;
            start_cycle   = 0;
            ray_idx       = 0;
            frame_idx     = 0;
            frame_errors  = 0;
            rays_expected = 0;
            scan_left     = 0;
            error_count   = 0;
            frames_passed = 0;
            frames_failed = 0;
        end else begin
            cycle = cycle + 1;
            // busy high from the edge after start, one cycle per pixel
            if (busy != (scan_left > 0)) begin
                report_int("busy", int'(scan_left > 0), int'(busy));
            end
            if (scan_left > 0) begin
                scan_left = scan_left - 1;
            end
            // only a start taken while idle opens a frame
            if (start && scan_left == 0 && !in_frame) begin
                in_frame      = 1'b1;
                start_cycle   = cycle;
                ray_idx       = 0;
                frame_errors  = 0;
                scan_left     = SCREEN_WIDTH * SCREEN_HEIGHT;
                fwd           = camera_forward;
                rays_expected = expected_rays;
                z_neg         = expect_z_neg;
            end
            if (ray_valid) begin
                if (!in_frame) begin
                    report_failure("ray_valid high outside a frame");
                end else begin
                    if (ray_idx == 0 && cycle - start_cycle != FIRST_RAY_DELAY) begin
                        report_int("ray_valid delay", FIRST_RAY_DELAY, cycle - start_cycle);
                    end
                    check_ray();
                    ray_idx = ray_idx + 1;
                    if (frame_done) begin
                        if (ray_idx != rays_expected) begin
                            report_int("frame_done ray count", rays_expected, ray_idx);
                        end
                        close_frame();
                    end else if (ray_idx >= rays_expected) begin
                        report_failure("last ray of the frame came without frame_done");
                    end
                end
            end else begin
                if (frame_done) begin
                    report_failure("frame_done high without ray_valid");
                end
                // rays must come back to back once the first is out
                if (in_frame && ray_idx > 0) begin
                    report_failure("gap in ray_valid inside a frame");
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/ray_frame_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module ray_frame_tb;

    import raygen_pkg::*;

    // small screen keeps the run short
    localparam int SCREEN_W   = 8;
    localparam int SCREEN_H   = 6;
    localparam int FRAME_ROWS = 6;
    localparam int PIXELS     = SCREEN_W * SCREEN_H;
    // per frame: every pixel, pipeline drain and the longest idle gap, plus slack
    localparam int TIMEOUT_CYCLES = FRAME_ROWS * (PIXELS + RAY_LATENCY + 8) + 50;

    // one camera setting and what its frame should look like
    typedef struct packed {
        vec3         fwd;
        logic        z_neg;
        logic [15:0] rays;
    } frame_row_t;

    logic       clk;
    logic       rst;
    logic       start;
    vec3        camera_forward;
    vec3        ray_direction;
    pixel_t     ray_pixel;
    logic       ray_valid;
    logic       frame_done;
    logic       busy;
    int         expected_rays;
    logic       expect_z_neg;
    int         error_count;
    int         frames_passed;
    int         frames_failed;
    int         cycle_count;
    integer     seed;
    frame_row_t frame_table [0:FRAME_ROWS-1];

    ray_frame_top #(
        .SCREEN_WIDTH  (SCREEN_W),
        .SCREEN_HEIGHT (SCREEN_H)
    ) ray_frame_top_inst (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .camera_forward (camera_forward),
        .ray_direction  (ray_direction),
        .ray_pixel      (ray_pixel),
        .ray_valid      (ray_valid),
        .frame_done     (frame_done),
        .busy           (busy)
    );

    ray_frame_checker #(
        .SCREEN_WIDTH  (SCREEN_W),
        .SCREEN_HEIGHT (SCREEN_H)
    ) ray_frame_checker_inst (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .busy           (busy),
        .camera_forward (camera_forward),
        .ray_direction  (ray_direction),
        .ray_pixel      (ray_pixel),
        .ray_valid      (ray_valid),
        .frame_done     (frame_done),
        .expected_rays  (expected_rays),
        .expect_z_neg   (expect_z_neg),
        .error_count    (error_count),
        .frames_passed  (frames_passed),
        .frames_failed  (frames_failed)
    );

    // real value into Q8.24
    function automatic fp to_fp(input real r);
        return fp'($rtoi(r * 16777216.0));
    endfunction

    function automatic frame_row_t make_row(input real fx, input real fy, input real fz);
        frame_row_t row;
        row.fwd   = make_vec3(to_fp(fx), to_fp(fy), to_fp(fz));
        // ray z is minus forward z for every pixel
        row.z_neg = (fz > 0.0);
        row.rays  = 16'(PIXELS);
        return row;
    endfunction

    // one frame, plus a stray start while the scanner is busy
    task automatic run_frame(input int row);
        int offset;
        camera_forward <= frame_table[row].fwd;
        expected_rays  <= int'(frame_table[row].rays);
        expect_z_neg   <= frame_table[row].z_neg;
        start          <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        offset = 1 + ($unsigned($random(seed)) % 30);
        repeat (offset) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!frame_done) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hard stop
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", cycle_count);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int gap;
        seed           = 32'h4686_6fc9;
        rst            = 1'b0;
        start          = 1'b0;
        camera_forward = '0;
        expected_rays  = 0;
        expect_z_neg   = 1'b0;
        frame_table[0] = make_row(0.0, 0.0, 1.0);
        frame_table[1] = make_row(0.0, 0.0, 2.0);
        frame_table[2] = make_row(0.5, 0.0, 1.0);
        frame_table[3] = make_row(0.0, -0.25, 1.5);
        frame_table[4] = make_row(0.3, 0.2, 0.75);
        // camera looking backwards
        frame_table[5] = make_row(0.0, 0.0, -1.0);
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        for (int r = 0; r < FRAME_ROWS; r++) begin
            run_frame(r);
            gap = $unsigned($random(seed)) % 6;
            repeat (gap) @(posedge clk);
        end
        // quiet tail, no late rays allowed
        repeat (RAY_LATENCY + 2) @(posedge clk);
        $display("summary: %0d frames passed, %0d frames failed, %0d errors",
                 frames_passed, frames_failed, error_count);
        if (error_count == 0 && frames_passed == FRAME_ROWS && frames_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/raygen_pkg.sv
design/inv_sqrt.sv
design/ray_generator.sv
design/pixel_scanner.sv
design/ray_frame_top.sv
verification/ray_frame_properties.sv
verification/ray_frame_checker.sv
verification/ray_frame_tb.sv

// ==== Makefile ====
# Verilator build and run for the ray frame testbench

TOP := ray_frame_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -Mdir $(OBJ)

# failure line in the log, or no pass line at all, fails the target
run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ) $(LOG)
